/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

  localparam int ILEN = 32;  // base instruction width
  localparam int CLEN = 16;  // compressed halfword width

  // major opcodes, low two bits always 11
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_JAL    = 7'h6f;

  localparam logic [2:0] F3_ADD = 3'b000;  // add, addi, sub
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;  // lw and sw share it
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SR  = 3'b101;  // srli and srai
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  localparam logic [6:0] F7_ALT = 7'b0100000;  // sub, srai

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  localparam logic [ILEN-1:0] EBREAK_WORD = 32'h0010_0073;

endpackage

/* rtl/rvc_pkg.sv */
package rvc_pkg;

  // quadrant in bits 1:0
  localparam logic [1:0] Q0     = 2'b00;
  localparam logic [1:0] Q1     = 2'b01;
  localparam logic [1:0] Q2     = 2'b10;
  localparam logic [1:0] Q_NONE = 2'b11;  // full 32-bit word

  localparam int RVC_OP_W = 5;

  localparam logic [RVC_OP_W-1:0] RVC_OP_PASS     = 5'd0;
  localparam logic [RVC_OP_W-1:0] RVC_OP_ADDI4SPN = 5'd1;
  localparam logic [RVC_OP_W-1:0] RVC_OP_LW       = 5'd2;
  localparam logic [RVC_OP_W-1:0] RVC_OP_SW       = 5'd3;
  localparam logic [RVC_OP_W-1:0] RVC_OP_ADDI     = 5'd4;  // c.nop too
  localparam logic [RVC_OP_W-1:0] RVC_OP_LI       = 5'd5;
  localparam logic [RVC_OP_W-1:0] RVC_OP_LUI      = 5'd6;
  localparam logic [RVC_OP_W-1:0] RVC_OP_ADDI16SP = 5'd7;
  localparam logic [RVC_OP_W-1:0] RVC_OP_SRLI     = 5'd8;
  localparam logic [RVC_OP_W-1:0] RVC_OP_SRAI     = 5'd9;
  localparam logic [RVC_OP_W-1:0] RVC_OP_ANDI     = 5'd10;
  localparam logic [RVC_OP_W-1:0] RVC_OP_SUB      = 5'd11;
  localparam logic [RVC_OP_W-1:0] RVC_OP_XOR      = 5'd12;
  localparam logic [RVC_OP_W-1:0] RVC_OP_OR       = 5'd13;
  localparam logic [RVC_OP_W-1:0] RVC_OP_AND      = 5'd14;
  localparam logic [RVC_OP_W-1:0] RVC_OP_J        = 5'd15;
  localparam logic [RVC_OP_W-1:0] RVC_OP_BEQZ     = 5'd16;
  localparam logic [RVC_OP_W-1:0] RVC_OP_BNEZ     = 5'd17;
  localparam logic [RVC_OP_W-1:0] RVC_OP_SLLI     = 5'd18;
  localparam logic [RVC_OP_W-1:0] RVC_OP_LWSP     = 5'd19;
  localparam logic [RVC_OP_W-1:0] RVC_OP_SWSP     = 5'd20;
  localparam logic [RVC_OP_W-1:0] RVC_OP_MV       = 5'd21;
  localparam logic [RVC_OP_W-1:0] RVC_OP_ADD      = 5'd22;
  localparam logic [RVC_OP_W-1:0] RVC_OP_JR       = 5'd23;
  localparam logic [RVC_OP_W-1:0] RVC_OP_JALR     = 5'd24;
  localparam logic [RVC_OP_W-1:0] RVC_OP_EBREAK   = 5'd25;

  localparam logic [1:0] RVC_PRIME_BASE = 2'b01;  // x8..x15

  typedef struct packed {
    logic [3:0] funct4;
    logic [4:0] rd_rs1;
    logic [4:0] rs2;
    logic [1:0] op;
  } rvc_cr_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;  // bit 12
    logic [4:0] rd_rs1;
    logic [4:0] imm_lo;  // bits 6:2
    logic [1:0] op;
  } rvc_ci_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [5:0] imm;
    logic [4:0] rs2;
    logic [1:0] op;
  } rvc_css_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [7:0] imm;
    logic [2:0] rd_p;
    logic [1:0] op;
  } rvc_ciw_t;

  // shared by loads and stores
  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;
    logic [2:0] rs1_p;
    logic [1:0] imm_lo;
    logic [2:0] rd_rs2_p;
    logic [1:0] op;
  } rvc_cls_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;
    logic [1:0] funct2;  // bits 11:10, offset bits on branches
    logic [2:0] rs1_p;
    logic [4:0] imm_lo;
    logic [1:0] op;
  } rvc_cb_t;

  typedef struct packed {
    logic [2:0]  funct3;
    logic [10:0] target;
    logic [1:0]  op;
  } rvc_cj_t;

  typedef union packed {
    rvc_cr_t  cr;
    rvc_ci_t  ci;
    rvc_css_t css;
    rvc_ciw_t ciw;
    rvc_cls_t cls;
    rvc_cb_t  cb;
    rvc_cj_t  cj;
  } rvc_inst_u;

endpackage

/* rtl/rvc_stage_if.sv */
`timescale 1ns/10ps

interface rvc_stage_if;

  logic                         valid;
  logic                         ready;
  logic [rv_isa_pkg::ILEN-1:0]  word;  // fetch word as received
  logic [rvc_pkg::RVC_OP_W-1:0] op;
  logic                         compressed;
  logic                         illegal;

  modport producer (
    output valid,
    output word,
    output op,
    output compressed,
    output illegal,
    input  ready
  );

  modport consumer (
    input  valid,
    input  word,
    input  op,
    input  compressed,
    input  illegal,
    output ready
  );

endinterface

/* rtl/rvc_classify.sv */
`timescale 1ns/10ps

module rvc_classify (
  input  logic                        i_clk,
  input  logic                        i_reset,
  input  logic                        i_valid,
  output logic                        o_ready,
  input  logic [rv_isa_pkg::ILEN-1:0] i_inst,
  rvc_stage_if.producer               o_stage
);

  rvc_pkg::rvc_inst_u           half;
  logic [rvc_pkg::RVC_OP_W-1:0] op_next;
  logic                         illegal_next;
  logic                         compressed_next;
  logic                         zero_imm;
  logic                         take;

  logic                         valid_q;
  logic [rv_isa_pkg::ILEN-1:0]  word_q;
  logic [rvc_pkg::RVC_OP_W-1:0] op_q;
  logic                         compressed_q;
  logic                         illegal_q;

  assign half            = i_inst[rv_isa_pkg::CLEN-1:0];
  assign compressed_next = (half.cr.op != rvc_pkg::Q_NONE);
  assign zero_imm        = ({half.ci.imm_hi, half.ci.imm_lo} == 6'b0);  // bit 12 and 6:2

  assign o_ready = !valid_q || o_stage.ready;
  assign take    = i_valid && o_ready;

  always_comb begin
    op_next      = rvc_pkg::RVC_OP_PASS;
    illegal_next = 1'b0;
    case (half.cr.op)
      rvc_pkg::Q0: begin
        case (half.ci.funct3)
          3'b000: begin
            op_next      = rvc_pkg::RVC_OP_ADDI4SPN;
            illegal_next = (half.ciw.imm == 8'b0);
          end
          3'b010:  op_next = rvc_pkg::RVC_OP_LW;
          3'b110:  op_next = rvc_pkg::RVC_OP_SW;
          default: illegal_next = 1'b1;  // fp, rv64 and reserved slots
        endcase
      end
      rvc_pkg::Q1: begin
        case (half.ci.funct3)
          3'b000:  op_next = rvc_pkg::RVC_OP_ADDI;
          3'b010:  op_next = rvc_pkg::RVC_OP_LI;
          3'b011: begin
            op_next      = (half.ci.rd_rs1 == rv_isa_pkg::REG_SP) ?
                           rvc_pkg::RVC_OP_ADDI16SP : rvc_pkg::RVC_OP_LUI;
            illegal_next = zero_imm;
          end
          3'b100: begin
            case (half.cb.funct2)
              2'b00: begin
                op_next      = rvc_pkg::RVC_OP_SRLI;
                illegal_next = zero_imm;
              end
              2'b01: begin
                op_next      = rvc_pkg::RVC_OP_SRAI;
                illegal_next = zero_imm;
              end
              2'b10:   op_next = rvc_pkg::RVC_OP_ANDI;
              default: begin
                case ({half.cb.imm_hi, half.cb.imm_lo[4:3]})
                  3'b000:  op_next = rvc_pkg::RVC_OP_SUB;
                  3'b001:  op_next = rvc_pkg::RVC_OP_XOR;
                  3'b010:  op_next = rvc_pkg::RVC_OP_OR;
                  3'b011:  op_next = rvc_pkg::RVC_OP_AND;
                  default: illegal_next = 1'b1;  // word ops and reserved
                endcase
              end
            endcase
          end
          3'b101:  op_next = rvc_pkg::RVC_OP_J;
          3'b110:  op_next = rvc_pkg::RVC_OP_BEQZ;
          3'b111:  op_next = rvc_pkg::RVC_OP_BNEZ;
          default: illegal_next = 1'b1;  // c.jal / c.addiw slot, not handled
        endcase
      end
      rvc_pkg::Q2: begin
        case (half.ci.funct3)
          3'b000: begin
            op_next      = rvc_pkg::RVC_OP_SLLI;
            illegal_next = zero_imm || (half.ci.rd_rs1 == rv_isa_pkg::REG_ZERO);
          end
          3'b010: begin
            op_next      = rvc_pkg::RVC_OP_LWSP;
            illegal_next = (half.ci.rd_rs1 == rv_isa_pkg::REG_ZERO);
          end
          3'b100: begin
            if (!half.cr.funct4[0]) begin
              if (half.cr.rs2 != rv_isa_pkg::REG_ZERO) begin
                op_next = rvc_pkg::RVC_OP_MV;
              end else begin
                op_next      = rvc_pkg::RVC_OP_JR;
                illegal_next = (half.cr.rd_rs1 == rv_isa_pkg::REG_ZERO);
              end
            end else if (half.cr.rs2 != rv_isa_pkg::REG_ZERO) begin
              op_next = rvc_pkg::RVC_OP_ADD;
            end else if (half.cr.rd_rs1 == rv_isa_pkg::REG_ZERO) begin
              op_next = rvc_pkg::RVC_OP_EBREAK;
            end else begin
              op_next = rvc_pkg::RVC_OP_JALR;
            end
          end
          3'b110:  op_next = rvc_pkg::RVC_OP_SWSP;
          default: illegal_next = 1'b1;
        endcase
      end
      default: ;  // not compressed, pass through
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      valid_q <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      word_q       <= i_inst;
      op_q         <= op_next;
      compressed_q <= compressed_next;
      illegal_q    <= illegal_next;
    end
  end

  assign o_stage.valid      = valid_q;
  assign o_stage.word       = word_q;
  assign o_stage.op         = op_q;
  assign o_stage.compressed = compressed_q;
  assign o_stage.illegal    = illegal_q;

  // an illegal flag is only ever raised on a compressed encoding
  a_illegal_is_compressed: assert property (@(posedge i_clk) disable iff (i_reset)
    o_stage.valid && o_stage.illegal |-> o_stage.compressed);

endmodule

/* rtl/rvc_expand.sv */
`timescale 1ns/10ps

module rvc_expand (
  input  logic                        i_clk,
  input  logic                        i_reset,
  rvc_stage_if.consumer               i_stage,
  output logic                        o_valid,
  input  logic                        i_ready,
  output logic [rv_isa_pkg::ILEN-1:0] o_inst,
  output logic                        o_compressed,
  output logic                        o_illegal
);

  rvc_pkg::rvc_inst_u          c;
  logic [rv_isa_pkg::ILEN-1:0] inst_next;
  logic [11:0]                 ci_imm;    // sign extended 6-bit immediate
  logic [4:0]                  rs1_prime; // bits 9:7 mapped to x8..x15
  logic [4:0]                  rs2_prime; // bits 4:2 mapped to x8..x15
  logic                        take;

  assign c         = i_stage.word[rv_isa_pkg::CLEN-1:0];
  assign ci_imm    = {{6{c.ci.imm_hi}}, c.ci.imm_hi, c.ci.imm_lo};
  assign rs1_prime = {rvc_pkg::RVC_PRIME_BASE, c.cls.rs1_p};
  assign rs2_prime = {rvc_pkg::RVC_PRIME_BASE, c.cls.rd_rs2_p};

  assign i_stage.ready = !o_valid || i_ready;
  assign take          = i_stage.valid && i_stage.ready;

  always_comb begin
    inst_next = i_stage.word;
    if (!i_stage.illegal) begin
      case (i_stage.op)
        rvc_pkg::RVC_OP_ADDI4SPN: inst_next = {2'b0, c.ciw.imm[5:2], c.ciw.imm[7:6],
          c.ciw.imm[0], c.ciw.imm[1], 2'b00, rv_isa_pkg::REG_SP, rv_isa_pkg::F3_ADD,
          rvc_pkg::RVC_PRIME_BASE, c.ciw.rd_p, rv_isa_pkg::OPC_OP_IMM};
        rvc_pkg::RVC_OP_LW: inst_next = {5'b0, c.cls.imm_lo[0], c.cls.imm_hi,
          c.cls.imm_lo[1], 2'b00, rs1_prime, rv_isa_pkg::F3_LW, rs2_prime,
          rv_isa_pkg::OPC_LOAD};
        rvc_pkg::RVC_OP_SW: inst_next = {5'b0, c.cls.imm_lo[0], c.cls.imm_hi[2],
          rs2_prime, rs1_prime, rv_isa_pkg::F3_LW, c.cls.imm_hi[1:0], c.cls.imm_lo[1],
          2'b00, rv_isa_pkg::OPC_STORE};
        rvc_pkg::RVC_OP_ADDI: inst_next = {ci_imm, c.ci.rd_rs1, rv_isa_pkg::F3_ADD,
          c.ci.rd_rs1, rv_isa_pkg::OPC_OP_IMM};
        rvc_pkg::RVC_OP_LI: inst_next = {ci_imm, rv_isa_pkg::REG_ZERO, rv_isa_pkg::F3_ADD,
          c.ci.rd_rs1, rv_isa_pkg::OPC_OP_IMM};
        rvc_pkg::RVC_OP_LUI: inst_next = {{15{c.ci.imm_hi}}, c.ci.imm_lo, c.ci.rd_rs1,
          rv_isa_pkg::OPC_LUI};
        // nzimm[9|4|6|8:7|5] sits in bits 12 and 6:2
        rvc_pkg::RVC_OP_ADDI16SP: inst_next = {{3{c.ci.imm_hi}}, c.ci.imm_lo[2:1],
          c.ci.imm_lo[3], c.ci.imm_lo[0], c.ci.imm_lo[4], 4'b0, rv_isa_pkg::REG_SP,
          rv_isa_pkg::F3_ADD, rv_isa_pkg::REG_SP, rv_isa_pkg::OPC_OP_IMM};
        rvc_pkg::RVC_OP_SRLI: inst_next = {6'b0, c.cb.imm_hi, c.cb.imm_lo, rs1_prime,
          rv_isa_pkg::F3_SR, rs1_prime, rv_isa_pkg::OPC_OP_IMM};
        rvc_pkg::RVC_OP_SRAI: inst_next = {rv_isa_pkg::F7_ALT[6:1], c.cb.imm_hi,
          c.cb.imm_lo, rs1_prime, rv_isa_pkg::F3_SR, rs1_prime, rv_isa_pkg::OPC_OP_IMM};
        rvc_pkg::RVC_OP_ANDI: inst_next = {ci_imm, rs1_prime, rv_isa_pkg::F3_AND,
          rs1_prime, rv_isa_pkg::OPC_OP_IMM};
        rvc_pkg::RVC_OP_SUB: inst_next = {rv_isa_pkg::F7_ALT, rs2_prime, rs1_prime,
          rv_isa_pkg::F3_ADD, rs1_prime, rv_isa_pkg::OPC_OP};
        rvc_pkg::RVC_OP_XOR: inst_next = {7'b0, rs2_prime, rs1_prime,
          rv_isa_pkg::F3_XOR, rs1_prime, rv_isa_pkg::OPC_OP};
        rvc_pkg::RVC_OP_OR: inst_next = {7'b0, rs2_prime, rs1_prime,
          rv_isa_pkg::F3_OR, rs1_prime, rv_isa_pkg::OPC_OP};
        rvc_pkg::RVC_OP_AND: inst_next = {7'b0, rs2_prime, rs1_prime,
          rv_isa_pkg::F3_AND, rs1_prime, rv_isa_pkg::OPC_OP};
        // offset[11|4|9:8|10|6|7|3:1|5] in target
        rvc_pkg::RVC_OP_J: inst_next = {c.cj.target[10], c.cj.target[6],
          c.cj.target[8:7], c.cj.target[4], c.cj.target[5], c.cj.target[0],
          c.cj.target[9], c.cj.target[3:1], {9{c.cj.target[10]}},
          rv_isa_pkg::REG_ZERO, rv_isa_pkg::OPC_JAL};
        rvc_pkg::RVC_OP_BEQZ: inst_next = {{4{c.cb.imm_hi}}, c.cb.imm_lo[4:3],
          c.cb.imm_lo[0], rv_isa_pkg::REG_ZERO, rs1_prime, rv_isa_pkg::F3_BEQ,
          c.cb.funct2, c.cb.imm_lo[2:1], c.cb.imm_hi, rv_isa_pkg::OPC_BRANCH};
        rvc_pkg::RVC_OP_BNEZ: inst_next = {{4{c.cb.imm_hi}}, c.cb.imm_lo[4:3],
          c.cb.imm_lo[0], rv_isa_pkg::REG_ZERO, rs1_prime, rv_isa_pkg::F3_BNE,
          c.cb.funct2, c.cb.imm_lo[2:1], c.cb.imm_hi, rv_isa_pkg::OPC_BRANCH};
        rvc_pkg::RVC_OP_SLLI: inst_next = {6'b0, c.ci.imm_hi, c.ci.imm_lo, c.ci.rd_rs1,
          rv_isa_pkg::F3_SLL, c.ci.rd_rs1, rv_isa_pkg::OPC_OP_IMM};
        rvc_pkg::RVC_OP_LWSP: inst_next = {4'b0, c.ci.imm_lo[1:0], c.ci.imm_hi,
          c.ci.imm_lo[4:2], 2'b00, rv_isa_pkg::REG_SP, rv_isa_pkg::F3_LW, c.ci.rd_rs1,
          rv_isa_pkg::OPC_LOAD};
        rvc_pkg::RVC_OP_SWSP: inst_next = {4'b0, c.css.imm[1:0], c.css.imm[5],
          c.css.rs2, rv_isa_pkg::REG_SP, rv_isa_pkg::F3_LW, c.css.imm[4:2], 2'b00,
          rv_isa_pkg::OPC_STORE};
        rvc_pkg::RVC_OP_MV: inst_next = {7'b0, c.cr.rs2, rv_isa_pkg::REG_ZERO,
          rv_isa_pkg::F3_ADD, c.cr.rd_rs1, rv_isa_pkg::OPC_OP};
        rvc_pkg::RVC_OP_ADD: inst_next = {7'b0, c.cr.rs2, c.cr.rd_rs1,
          rv_isa_pkg::F3_ADD, c.cr.rd_rs1, rv_isa_pkg::OPC_OP};
        rvc_pkg::RVC_OP_JR: inst_next = {12'b0, c.cr.rd_rs1, 3'b000,
          rv_isa_pkg::REG_ZERO, rv_isa_pkg::OPC_JALR};
        rvc_pkg::RVC_OP_JALR: inst_next = {12'b0, c.cr.rd_rs1, 3'b000,
          rv_isa_pkg::REG_RA, rv_isa_pkg::OPC_JALR};
        rvc_pkg::RVC_OP_EBREAK: inst_next = rv_isa_pkg::EBREAK_WORD;
        default: inst_next = i_stage.word;  // RVC_OP_PASS
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (i_stage.ready) begin
      o_valid <= i_stage.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      o_inst       <= inst_next;
      o_compressed <= i_stage.compressed;
      o_illegal    <= i_stage.illegal;
    end
  end

  // held output item must not change under back-pressure
  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    o_valid && !i_ready |=> o_valid && $stable(o_inst) && $stable(o_compressed)
      && $stable(o_illegal));

endmodule

/* rtl/rvc_decoder_top.sv */
`timescale 1ns/10ps

module rvc_decoder_top (
  input  logic                        i_clk,
  input  logic                        i_reset,
  input  logic                        i_valid,
  input  logic [rv_isa_pkg::ILEN-1:0] i_inst,
  output logic                        o_ready,
  output logic                        o_valid,
  input  logic                        i_ready,
  output logic [rv_isa_pkg::ILEN-1:0] o_inst,
  output logic                        o_compressed,
  output logic                        o_illegal
);

  rvc_stage_if stage_if ();  // classify -> expand

  rvc_classify rvc_classify_inst (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .i_inst  (i_inst),
    .o_stage (stage_if.producer)
  );

  rvc_expand rvc_expand_inst (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_stage      (stage_if.consumer),
    .o_valid      (o_valid),
    .i_ready      (i_ready),
    .o_inst       (o_inst),
    .o_compressed (o_compressed),
    .o_illegal    (o_illegal)
  );

endmodule

/* include/rvc_ref_model.svh */
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

// expected 32-bit form of a legal compressed halfword, straight from the C spec tables
function automatic logic [rv_isa_pkg::ILEN-1:0] ref_expand(input logic [15:0] h);
  logic [4:0]  rdp;
  logic [4:0]  rs2p;
  logic [11:0] imm6;
  logic [9:0]  a4;
  logic [6:0]  lw;
  logic [9:0]  sp16;
  logic [11:0] jo;
  logic [12:0] bi;
  logic [7:0]  lsp;
  logic [7:0]  ssp;
  logic [2:0]  f3;
  logic [31:0] r;
  rdp  = {2'b01, h[9:7]};
  rs2p = {2'b01, h[4:2]};
  imm6 = {{6{h[12]}}, h[12], h[6:2]};
  a4   = {h[10:7], h[12:11], h[5], h[6], 2'b00};
  lw   = {h[5], h[12:10], h[6], 2'b00};
  sp16 = {h[12], h[4:3], h[5], h[2], h[6], 4'b0000};
  jo   = {h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
  bi   = {{4{h[12]}}, h[12], h[6:5], h[2], h[11:10], h[4:3], 1'b0};
  lsp  = {h[3:2], h[12], h[6:4], 2'b00};
  ssp  = {h[8:7], h[12:9], 2'b00};
  r    = 32'h0;
  case ({h[1:0], h[15:13]})
    5'b00_000: r = {2'b00, a4, 5'd2, 3'b000, rs2p, 7'h13};
    5'b00_010: r = {5'b0, lw, rdp, 3'b010, rs2p, 7'h03};
    5'b00_110: r = {5'b0, lw[6:5], rs2p, rdp, 3'b010, lw[4:0], 7'h23};
    5'b01_000: r = {imm6, h[11:7], 3'b000, h[11:7], 7'h13};
    5'b01_010: r = {imm6, 5'd0, 3'b000, h[11:7], 7'h13};
    5'b01_011: begin
      if (h[11:7] == 5'd2) begin
        r = {{2{h[12]}}, sp16, 5'd2, 3'b000, 5'd2, 7'h13};  // c.addi16sp
      end else begin
        r = {{15{h[12]}}, h[6:2], h[11:7], 7'h37};
      end
    end
    5'b01_100: begin
      case (h[6:5])
        2'b00:   f3 = 3'b000;
        2'b01:   f3 = 3'b100;
        2'b10:   f3 = 3'b110;
        default: f3 = 3'b111;
      endcase
      case (h[11:10])
        2'b00:   r = {6'b000000, h[12], h[6:2], rdp, 3'b101, rdp, 7'h13};
        2'b01:   r = {6'b010000, h[12], h[6:2], rdp, 3'b101, rdp, 7'h13};
        2'b10:   r = {imm6, rdp, 3'b111, rdp, 7'h13};
        default: r = {(h[6:5] == 2'b00) ? 7'h20 : 7'h00, rs2p, rdp, f3, rdp, 7'h33};
      endcase
    end
    5'b01_101: r = {jo[11], jo[10:1], jo[11], {8{h[12]}}, 5'd0, 7'h6f};
    5'b01_110: r = {bi[12], bi[10:5], 5'd0, rdp, 3'b000, bi[4:1], bi[11], 7'h63};
    5'b01_111: r = {bi[12], bi[10:5], 5'd0, rdp, 3'b001, bi[4:1], bi[11], 7'h63};
    5'b10_000: r = {6'b0, h[12], h[6:2], h[11:7], 3'b001, h[11:7], 7'h13};
    5'b10_010: r = {4'b0, lsp, 5'd2, 3'b010, h[11:7], 7'h03};
    5'b10_110: r = {4'b0, ssp[7:5], h[6:2], 5'd2, 3'b010, ssp[4:0], 7'h23};
    5'b10_100: begin
      if (!h[12] && h[6:2] != 5'd0) begin
        r = {7'b0, h[6:2], 5'd0, 3'b000, h[11:7], 7'h33};      // c.mv
      end else if (!h[12]) begin
        r = {12'b0, h[11:7], 3'b000, 5'd0, 7'h67};              // c.jr
      end else if (h[6:2] != 5'd0) begin
        r = {7'b0, h[6:2], h[11:7], 3'b000, h[11:7], 7'h33};   // c.add
      end else if (h[11:7] == 5'd0) begin
        r = rv_isa_pkg::EBREAK_WORD;
      end else begin
        r = {12'b0, h[11:7], 3'b000, 5'd1, 7'h67};              // c.jalr
      end
    end
    default: r = 32'h0;
  endcase
  return r;
endfunction

// rv32 legality of a halfword whose low bits are not 11
function automatic logic ref_illegal(input logic [15:0] h);
  logic ill;
  ill = 1'b1;  // unlisted slots are rv64, fp or reserved
  case ({h[1:0], h[15:13]})
    5'b00_000: ill = (h[12:5] == 8'd0);
    5'b00_010, 5'b00_110, 5'b01_000, 5'b01_010: ill = 1'b0;
    5'b01_101, 5'b01_110, 5'b01_111, 5'b10_110: ill = 1'b0;
    5'b01_011: ill = ({h[12], h[6:2]} == 6'd0);
    5'b01_100: begin
      case (h[11:10])
        2'b00, 2'b01: ill = ({h[12], h[6:2]} == 6'd0);
        2'b10:        ill = 1'b0;
        default:      ill = h[12];  // subw, addw and reserved
      endcase
    end
    5'b10_000: ill = ({h[12], h[6:2]} == 6'd0) || (h[11:7] == 5'd0);
    5'b10_010: ill = (h[11:7] == 5'd0);
    5'b10_100: ill = !h[12] && (h[6:2] == 5'd0) && (h[11:7] == 5'd0);
    default:   ill = 1'b1;
  endcase
  return ill;
endfunction

`endif

/* bench/rvc_decoder_tb.sv */
`timescale 1ns/10ps

module rvc_decoder_tb;

  `include "rvc_ref_model.svh"

  localparam int N_RANDOM = 400;
  localparam int DEPTH    = 1024;

  logic        i_clk;
  logic        i_reset;
  logic        i_valid;
  logic [31:0] i_inst;
  logic        o_ready;
  logic        o_valid;
  logic        i_ready;
  logic [31:0] o_inst;
  logic        o_compressed;
  logic        o_illegal;

  string       stim_name[$];
  logic [31:0] stim_word[$];

  // scoreboard filled on input transfer and read on output transfer
  logic [31:0] exp_inst  [0:DEPTH-1];
  logic        exp_comp  [0:DEPTH-1];
  logic        exp_ill   [0:DEPTH-1];
  logic        exp_timed [0:DEPTH-1];
  int          exp_id    [0:DEPTH-1];
  int          exp_acc   [0:DEPTH-1];

  int          wr_ptr = 0;
  int          rd_ptr = 0;
  int          cycle = 0;
  int          cur_id = 0;
  logic        timed_phase = 1'b0;
  int          err_value = 0;
  int          err_other = 0;
  logic [31:0] rng;

  logic        head_valid;
  logic [31:0] head_inst;
  logic        head_comp;
  logic        head_ill;
  logic        head_timed;
  int          head_id;
  int          head_acc;

  assign head_valid = rd_ptr < wr_ptr;
  assign head_inst  = exp_inst[rd_ptr];
  assign head_comp  = exp_comp[rd_ptr];
  assign head_ill   = exp_ill[rd_ptr];
  assign head_timed = exp_timed[rd_ptr];
  assign head_id    = exp_id[rd_ptr];
  assign head_acc   = exp_acc[rd_ptr];

  rvc_decoder_top rvc_decoder_top_inst (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_inst       (i_inst),
    .o_ready      (o_ready),
    .o_valid      (o_valid),
    .i_ready      (i_ready),
    .o_inst       (o_inst),
    .o_compressed (o_compressed),
    .o_illegal    (o_illegal)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  always @(posedge i_clk) begin
    if (!i_reset && i_valid && o_ready) begin
      exp_comp[wr_ptr]  = (i_inst[1:0] != 2'b11);
      exp_ill[wr_ptr]   = exp_comp[wr_ptr] && ref_illegal(i_inst[15:0]);
      exp_inst[wr_ptr]  = (exp_comp[wr_ptr] && !exp_ill[wr_ptr]) ?
                          ref_expand(i_inst[15:0]) : i_inst;
      exp_timed[wr_ptr] = timed_phase;
      exp_id[wr_ptr]    = cur_id;
      exp_acc[wr_ptr]   = cycle;
      wr_ptr = wr_ptr + 1;
    end
    if (!i_reset && o_valid && i_ready) begin
      rd_ptr = rd_ptr + 1;
    end
    cycle = cycle + 1;
  end

  a_reset_idle: assert property (@(posedge i_clk) i_reset |=> !o_valid && o_ready)
    else begin
      err_other++;
      $display("output valid or input not ready during reset");
    end

  a_no_extra: assert property (@(posedge i_clk) disable iff (i_reset)
    o_valid && i_ready |-> head_valid)
    else begin
      err_other++;
      $display("output transfer without a matching input item");
    end

  a_inst: assert property (@(posedge i_clk) disable iff (i_reset)
    o_valid && i_ready && head_valid |-> o_inst == head_inst)
    else begin
      err_value++;
      $display("** Error %s: o_inst expected %h actual %h",
        stim_name[$sampled(head_id)], $sampled(head_inst), $sampled(o_inst));
    end

  a_comp: assert property (@(posedge i_clk) disable iff (i_reset)
    o_valid && i_ready && head_valid |-> o_compressed == head_comp)
    else begin
      err_value++;
      $display("** Error %s: o_compressed expected %b actual %b",
        stim_name[$sampled(head_id)], $sampled(head_comp), $sampled(o_compressed));
    end

  a_ill: assert property (@(posedge i_clk) disable iff (i_reset)
    o_valid && i_ready && head_valid |-> o_illegal == head_ill)
    else begin
      err_value++;
      $display("** Error %s: o_illegal expected %b actual %b",
        stim_name[$sampled(head_id)], $sampled(head_ill), $sampled(o_illegal));
    end

  // two cycles from acceptance to output when nothing stalls
  a_latency: assert property (@(posedge i_clk) disable iff (i_reset)
    o_valid && i_ready && head_valid && head_timed |-> cycle - head_acc == 2)
    else begin
      err_value++;
      $display("** Error %s: latency expected 2 actual %0d",
        stim_name[$sampled(head_id)], $sampled(cycle) - $sampled(head_acc));
    end

  a_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    o_valid && !i_ready |=> o_valid && $stable(o_inst) && $stable(o_compressed)
      && $stable(o_illegal))
    else begin
      err_other++;
      $display("output item changed or vanished while stalled");
    end

  task automatic add_case(input string name, input logic [15:0] h);
    stim_name.push_back(name);
    stim_word.push_back({16'ha5a5, h});  // upper half must survive a pass-through
  endtask

  task automatic run_items(input int first, input int last, input bit random_mode);
    int idx;
    logic accepted;
    idx = first;
    while (idx <= last) begin
      if (!i_valid) begin
        i_inst = stim_word[idx];
        cur_id = idx;
        i_valid = random_mode ? (next_rand() % 3 != 0) : 1'b1;
      end
      if (random_mode) begin
        i_ready = (next_rand() % 4 != 0);
      end
      @(posedge i_clk);
      accepted = i_valid && o_ready;
      #1;
      if (accepted) begin
        idx = idx + 1;
        i_valid = 1'b0;
      end
    end
    i_valid = 1'b0;
    i_ready = 1'b1;
  endtask

  task automatic drain();
    while (rd_ptr != wr_ptr) begin
      @(posedge i_clk);
    end
    #1;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] b;
    int n_dir;
    int n_all;
    i_reset = 1'b1;
    i_valid = 1'b1;  // input offered and output stalled while in reset
    i_inst  = 32'h0;
    i_ready = 1'b0;
    rng     = 32'h1cd3;

    stim_name.push_back("full addi");
    stim_word.push_back(32'h0050_0093);
    add_case("c.addi4spn", 16'h0040);
    add_case("c.addi4spn zero", 16'h0004);
    add_case("c.lw", 16'h4398);
    add_case("c.sw", 16'hc3d4);
    add_case("c.ld", 16'h6398);
    add_case("c.sd", 16'he398);
    add_case("c.fld", 16'h2398);
    add_case("q0 reserved", 16'h8398);
    add_case("c.nop", 16'h0001);
    add_case("c.addi", 16'h1ffd);
    add_case("c.li", 16'h5095);
    add_case("c.lui", 16'h7285);
    add_case("c.lui zero", 16'h6281);
    add_case("c.addi16sp", 16'h7101);
    add_case("c.addi16sp zero", 16'h6101);
    add_case("c.srli", 16'h8005);
    add_case("c.srli zero", 16'h8001);
    add_case("c.srai", 16'h8405);
    add_case("c.srai zero", 16'h8401);
    add_case("c.andi", 16'h9a7d);
    add_case("c.sub", 16'h8c05);
    add_case("c.xor", 16'h8c25);
    add_case("c.or", 16'h8c45);
    add_case("c.and", 16'h8c65);
    add_case("c.subw", 16'h9c05);
    add_case("c.addw", 16'h9c25);
    add_case("q1 reserved", 16'h9c45);
    add_case("c.j", 16'ha8a5);
    add_case("c.j back", 16'hb001);
    add_case("c.beqz", 16'hc8a5);
    add_case("c.bnez", 16'hfc7d);
    add_case("c.addiw slot", 16'h2005);
    add_case("c.slli", 16'h0506);
    add_case("c.slli zero", 16'h0502);
    add_case("c.slli rd0", 16'h0006);
    add_case("c.lwsp", 16'h40a2);
    add_case("c.lwsp rd0", 16'h4022);
    add_case("c.swsp", 16'hc206);
    add_case("c.mv", 16'h8506);
    add_case("c.jr", 16'h8082);
    add_case("c.jr x0", 16'h8002);
    add_case("c.add", 16'h9506);
    add_case("c.jalr", 16'h9082);
    add_case("c.ebreak", 16'h9002);
    add_case("c.ldsp", 16'h60a2);
    add_case("c.sdsp", 16'he206);
    add_case("c.fldsp", 16'h20a2);
    n_dir = stim_word.size();

    for (int k = 0; k < N_RANDOM; k++) begin
      r = next_rand();
      b = next_rand();
      if (b[1:0] != 2'b00) begin
        r[1:0] = b[1:0] - 2'd1;  // three quarters compressed
      end else begin
        r[1:0] = 2'b11;
      end
      stim_name.push_back($sformatf("random %0d", k));
      stim_word.push_back(r);
    end
    n_all = stim_word.size();

    fork
      begin
        #((n_all * 8 + 50) * 100);
        $display("watchdog expired before the run finished");
        $display("Errors found");
        $finish;
      end
    join_none

    repeat (5) @(posedge i_clk);
    #1;
    i_reset = 1'b0;
    i_valid = 1'b0;
    i_ready = 1'b1;

    timed_phase = 1'b1;
    run_items(0, n_dir - 1, 1'b0);
    drain();
    timed_phase = 1'b0;
    run_items(n_dir, n_all - 1, 1'b1);
    drain();
    repeat (3) @(posedge i_clk);

    if (wr_ptr != n_all || rd_ptr != n_all) begin
      err_other++;
      $display("item count mismatch, %0d sent, %0d accepted, %0d delivered",
        n_all, wr_ptr, rd_ptr);
    end
    $display("value errors %0d, other errors %0d", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
rtl/rv_isa_pkg.sv
rtl/rvc_pkg.sv
rtl/rvc_stage_if.sv
rtl/rvc_classify.sv
rtl/rvc_expand.sv
rtl/rvc_decoder_top.sv
bench/rvc_decoder_tb.sv

/* run.sh */
#!/bin/sh
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module rvc_decoder_tb -o rvc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rvc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^No errors$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
